/* hw/core_pkg.sv */
// core shared definitions
package core_pkg;

    // datapath and storage sizes
    localparam int word_width = 16;
    localparam int reg_count = 16;
    localparam int reg_idx_width = $clog2(reg_count);
    localparam int instr_depth = 4;
    localparam int queue_ptr_width = $clog2(instr_depth);
    localparam int queue_count_width = $clog2(instr_depth + 1);
    localparam int mem_words = 256;
    localparam int mem_addr_width = $clog2(mem_words);
    localparam int out_credit_width = 8;

    // unlisted codes decode as nop
    typedef enum logic [3:0] {
        op_nop   = 4'h0,
        op_add   = 4'h1,
        op_sub   = 4'h2,
        op_and   = 4'h3,
        op_xor   = 4'h4,
        op_addi  = 4'h5,
        op_load  = 4'h6,
        op_store = 4'h7,
        op_out   = 4'h8
    } opcode_t;

    // register format, also used by load, store and out
    typedef struct packed {
        logic [reg_idx_width-1:0] rs2;
        logic [reg_idx_width-1:0] rs1;
        logic [reg_idx_width-1:0] rd;
        opcode_t                  op;
    } r_fmt_t;

    // immediate format for addi
    typedef struct packed {
        logic [7:0]               imm;
        logic [reg_idx_width-1:0] rd;
        opcode_t                  op;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    typedef struct packed {
        logic                  valid;
        logic [word_width-1:0] data;
    } stream_word_t;

    typedef struct packed {
        logic                     valid;
        opcode_t                  op;
        logic [reg_idx_width-1:0] rd;
        logic [reg_idx_width-1:0] rs1;
        logic [reg_idx_width-1:0] rs2;
        logic [word_width-1:0]    a;
        logic [word_width-1:0]    b;
        logic [word_width-1:0]    imm;
        logic                     regwrite;
    } decoded_t;

    // result holds ALU value or address, data holds store or out value
    typedef struct packed {
        logic                     valid;
        opcode_t                  op;
        logic [reg_idx_width-1:0] rd;
        logic [word_width-1:0]    result;
        logic [word_width-1:0]    data;
        logic                     regwrite;
    } executed_t;

    typedef struct packed {
        logic                     valid;
        logic [reg_idx_width-1:0] rd;
        logic [word_width-1:0]    value;
    } writeback_t;

endpackage

/* hw/instr_queue.sv */
// instruction input queue
`timescale 1ns/1ps

module instr_queue (
    input  logic                   clock,
    input  logic                   reset,
    input  core_pkg::stream_word_t read_in,
    input  logic                   stall,
    output core_pkg::instr_t       head,
    output logic                   head_valid,
    output logic                   instr_credit
);

    core_pkg::instr_t buffer [core_pkg::instr_depth];
    logic [core_pkg::queue_ptr_width-1:0]   wr_ptr;
    logic [core_pkg::queue_ptr_width-1:0]   rd_ptr;
    logic [core_pkg::queue_count_width-1:0] count;
    logic push;
    logic pop;

    function automatic logic [core_pkg::queue_ptr_width-1:0] next_ptr(
        input logic [core_pkg::queue_ptr_width-1:0] ptr
    );
        if (int'(ptr) == core_pkg::instr_depth - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // source credits guarantee there is always room
    assign push = read_in.valid;
    assign head_valid = (count != '0);
    assign pop = head_valid && !stall;
    // one credit back per instruction handed to decode
    assign instr_credit = pop;
    assign head = buffer[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            buffer[wr_ptr] <= read_in.data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/decode_stage.sv */
// decode stage and register file
`timescale 1ns/1ps

module decode_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 stall,
    input  core_pkg::instr_t     head,
    input  logic                 head_valid,
    input  core_pkg::writeback_t wb,
    output core_pkg::decoded_t   decoded
);

    logic [core_pkg::word_width-1:0] regs [core_pkg::reg_count];
    core_pkg::decoded_t next_decoded;

    // register file, r0 is never written
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    always_comb begin
        next_decoded = '0;
        next_decoded.valid = head_valid;
        next_decoded.op = head.r_fmt.op;
        next_decoded.rd = head.r_fmt.rd;
        next_decoded.rs1 = head.r_fmt.rs1;
        case (head.r_fmt.op)
            core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and, core_pkg::op_xor: begin
                next_decoded.rs2 = head.r_fmt.rs2;
                next_decoded.regwrite = 1'b1;
            end
            core_pkg::op_addi: begin
                // rd is both source and destination
                next_decoded.rs1 = head.i_fmt.rd;
                next_decoded.imm = {{(core_pkg::word_width - 8){head.i_fmt.imm[7]}},
                                    head.i_fmt.imm};
                next_decoded.regwrite = 1'b1;
            end
            core_pkg::op_load: begin
                // 4-bit offset sits in the rs2 field
                next_decoded.imm = {{(core_pkg::word_width - 4){head.r_fmt.rs2[3]}},
                                    head.r_fmt.rs2};
                next_decoded.regwrite = 1'b1;
            end
            core_pkg::op_store: begin
                // store data comes from rd
                next_decoded.rs2 = head.r_fmt.rd;
                next_decoded.imm = {{(core_pkg::word_width - 4){head.r_fmt.rs2[3]}},
                                    head.r_fmt.rs2};
            end
            core_pkg::op_out: begin
                next_decoded.rd = '0;
            end
            default: begin
                next_decoded.op = core_pkg::op_nop;
                next_decoded.rd = '0;
                next_decoded.rs1 = '0;
            end
        endcase

        // read ports with write-through from writeback
        if (next_decoded.rs1 == '0) begin
            next_decoded.a = '0;
        end else if (wb.valid && wb.rd == next_decoded.rs1) begin
            next_decoded.a = wb.value;
        end else begin
            next_decoded.a = regs[next_decoded.rs1];
        end
        if (next_decoded.rs2 == '0) begin
            next_decoded.b = '0;
        end else if (wb.valid && wb.rd == next_decoded.rs2) begin
            next_decoded.b = wb.value;
        end else begin
            next_decoded.b = regs[next_decoded.rs2];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            decoded.valid <= 1'b0;
        end else if (!stall) begin
            decoded <= next_decoded;
        end
    end

endmodule

/* hw/execute_stage.sv */
// execute stage with forwarding and ALU
`timescale 1ns/1ps

module execute_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 stall,
    input  core_pkg::decoded_t   decoded,
    input  core_pkg::writeback_t wb,
    output core_pkg::executed_t  executed
);

    logic [core_pkg::word_width-1:0] op_a;
    logic [core_pkg::word_width-1:0] op_b;
    core_pkg::executed_t next_executed;

    // result stage value overrides stale operands
    always_comb begin
        op_a = decoded.a;
        op_b = decoded.b;
        if (wb.valid && decoded.rs1 != '0 && wb.rd == decoded.rs1) begin
            op_a = wb.value;
        end
        if (wb.valid && decoded.rs2 != '0 && wb.rd == decoded.rs2) begin
            op_b = wb.value;
        end
    end

    always_comb begin
        next_executed = '0;
        next_executed.valid = decoded.valid;
        next_executed.op = decoded.op;
        next_executed.rd = decoded.rd;
        next_executed.regwrite = decoded.regwrite;
        case (decoded.op)
            core_pkg::op_add: next_executed.result = op_a + op_b;
            core_pkg::op_sub: next_executed.result = op_a - op_b;
            core_pkg::op_and: next_executed.result = op_a & op_b;
            core_pkg::op_xor: next_executed.result = op_a ^ op_b;
            core_pkg::op_addi, core_pkg::op_load: begin
                next_executed.result = op_a + decoded.imm;
            end
            core_pkg::op_store: begin
                // address from base plus offset
                next_executed.result = op_a + decoded.imm;
                next_executed.data = op_b;
            end
            core_pkg::op_out: next_executed.data = op_a;
            default: next_executed.result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            executed.valid <= 1'b0;
        end else if (!stall) begin
            executed <= next_executed;
        end
    end

endmodule

/* hw/result_stage.sv */
// result stage, memory and output
`timescale 1ns/1ps

module result_stage (
    input  logic                   clock,
    input  logic                   reset,
    input  core_pkg::executed_t    executed,
    input  logic                   out_credit,
    output core_pkg::writeback_t   wb,
    output logic                   stall,
    output core_pkg::stream_word_t write_out
);

    logic [core_pkg::word_width-1:0]       dmem [core_pkg::mem_words];
    logic [core_pkg::mem_addr_width-1:0]   addr;
    logic [core_pkg::word_width-1:0]       load_data;
    logic [core_pkg::out_credit_width-1:0] credits;
    logic is_out;
    logic issue;

    // low bits of the effective address
    assign addr = executed.result[core_pkg::mem_addr_width-1:0];
    assign load_data = dmem[addr];

    always_ff @(posedge clock) begin
        if (executed.valid && executed.op == core_pkg::op_store) begin
            dmem[addr] <= executed.data;
        end
    end

    // load data goes straight back so execute can forward it
    always_comb begin
        wb.valid = executed.valid && executed.regwrite;
        wb.rd = executed.rd;
        if (executed.op == core_pkg::op_load) begin
            wb.value = load_data;
        end else begin
            wb.value = executed.result;
        end
    end

    assign is_out = executed.valid && executed.op == core_pkg::op_out;
    assign issue = is_out && credits != '0;
    // hold the whole pipe until the sink returns a credit
    assign stall = is_out && credits == '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= '0;
        end else begin
            case ({out_credit, issue})
                2'b10: credits <= credits + 1'b1;
                2'b01: credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            write_out.data <= executed.data;
        end
        if (reset) begin
            write_out.valid <= 1'b0;
        end else begin
            write_out.valid <= issue;
        end
    end

endmodule

/* hw/load_store.sv */
// pipelined load store core
`timescale 1ns/1ps

module load_store (
    input  logic                   clock,
    input  logic                   reset,
    input  core_pkg::stream_word_t read_in,
    input  logic                   out_credit,
    output logic                   instr_credit,
    output core_pkg::stream_word_t write_out
);

    core_pkg::instr_t     head;
    logic                 head_valid;
    logic                 stall;
    core_pkg::decoded_t   decoded;
    core_pkg::executed_t  executed;
    core_pkg::writeback_t wb;

    instr_queue i_instr_queue (
        .clock        (clock),
        .reset        (reset),
        .read_in      (read_in),
        .stall        (stall),
        .head         (head),
        .head_valid   (head_valid),
        .instr_credit (instr_credit)
    );

    decode_stage i_decode_stage (
        .clock      (clock),
        .reset      (reset),
        .stall      (stall),
        .head       (head),
        .head_valid (head_valid),
        .wb         (wb),
        .decoded    (decoded)
    );

    execute_stage i_execute_stage (
        .clock    (clock),
        .reset    (reset),
        .stall    (stall),
        .decoded  (decoded),
        .wb       (wb),
        .executed (executed)
    );

    // stall and writeback both come from the last stage
    result_stage i_result_stage (
        .clock      (clock),
        .reset      (reset),
        .executed   (executed),
        .out_credit (out_credit),
        .wb         (wb),
        .stall      (stall),
        .write_out  (write_out)
    );

endmodule

/* testbench/load_store_tb.sv */
// load store core testbench
`timescale 1ns/1ps

module load_store_tb;

    logic                   clock;
    logic                   reset;
    core_pkg::stream_word_t read_in;
    logic                   out_credit;
    logic                   instr_credit;
    core_pkg::stream_word_t write_out;

    logic [15:0] instr_q [$];
    logic [15:0] expected_q [$];
    integer seed;
    int src_credits;
    int sink_credits;
    int gap_left;
    int drought_left;
    int idle_cycles;
    int quiet_cycles;
    bit progress;

    load_store i_load_store (
        .clock        (clock),
        .reset        (reset),
        .read_in      (read_in),
        .out_credit   (out_credit),
        .instr_credit (instr_credit),
        .write_out    (write_out)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string reason);
        $display("%s, at time %0t", reason, $time);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("Error: time %0t, %s is %h, expected %h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic load_cases();
        int fd;
        int code;
        int fields;
        string line;
        logic [7:0] tag;
        logic [15:0] value;
        fd = $fopen("testbench/load_store_cases.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open testbench/load_store_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // blank and comment lines carry nothing
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%c %h", tag, value);
                if (fields == 2 && tag == "I") begin
                    instr_q.push_back(value);
                end else if (fields == 2 && tag == "E") begin
                    expected_q.push_back(value);
                end else begin
                    report_failure("unrecognized line in the cases file");
                end
            end
        end
        $fclose(fd);
        if (instr_q.size() == 0 || expected_q.size() == 0) begin
            report_failure("cases file holds no instructions or no expected words");
        end
    endtask

    task automatic count_instr_credit();
        if (instr_credit) begin
            src_credits++;
            if (src_credits > core_pkg::instr_depth) begin
                report_failure("instruction credit returned with none outstanding");
            end
        end
    endtask

    task automatic take_output();
        if (write_out.valid) begin
            if (sink_credits == 0) begin
                report_failure("write_out.valid high while the sink holds no credit");
            end else if (expected_q.size() == 0) begin
                report_failure("output word beyond the expected stream");
            end else begin
                sink_credits--;
                check_value("write_out.data", write_out.data, expected_q.pop_front());
                progress = 1'b1;
            end
        end
    endtask

    task automatic send_instruction();
        read_in = '0;
        if (gap_left > 0) begin
            gap_left--;
        end else if (instr_q.size() != 0 && src_credits > 0) begin
            read_in.valid = 1'b1;
            read_in.data = instr_q.pop_front();
            src_credits--;
            progress = 1'b1;
            // mostly back to back with an occasional short idle stretch
            if ($unsigned($random(seed)) % 4 == 0) begin
                gap_left = 1 + $unsigned($random(seed)) % 3;
            end
        end
    endtask

    task automatic give_out_credit();
        out_credit = 1'b0;
        if (drought_left > 0) begin
            drought_left--;
        end else if ($unsigned($random(seed)) % 16 == 0) begin
            drought_left = 1 + $unsigned($random(seed)) % 20;
        end else if (sink_credits < 4 && $unsigned($random(seed)) % 2 == 0) begin
            out_credit = 1'b1;
            sink_credits++;
        end
    endtask

    initial begin
        seed = 32'h84b6;
        reset = 1'b1;
        read_in = '0;
        out_credit = 1'b0;
        src_credits = core_pkg::instr_depth;
        sink_credits = 0;
        gap_left = 0;
        drought_left = 0;
        idle_cycles = 0;
        quiet_cycles = 0;
        progress = 1'b0;
        load_cases();

        repeat (8) begin
            @(negedge clock);
        end
        check_value("write_out.valid", write_out.valid, 1'b0);
        check_value("instr_credit", instr_credit, 1'b0);
        reset = 1'b0;

        // source and sink step together on each falling edge
        while (quiet_cycles < 50) begin
            @(negedge clock);
            progress = 1'b0;
            count_instr_credit();
            take_output();
            send_instruction();
            give_out_credit();
            if (progress) begin
                idle_cycles = 0;
            end else begin
                idle_cycles++;
            end
            if (idle_cycles > 2000) begin
                report_failure("timeout, core neither took an instruction nor emitted a word");
            end
            if (instr_q.size() == 0 && expected_q.size() == 0) begin
                quiet_cycles++;
            end
        end

        // every instruction handed on must have been credited back
        check_value("instruction credits", 16'(src_credits), 16'(core_pkg::instr_depth));
        $display("Regression passed");
        $finish;
    end

endmodule

/* build.f */
hw/core_pkg.sv
hw/instr_queue.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/load_store.sv
testbench/load_store_tb.sv

/* testbench/load_store_cases.txt */
# I hhhh: instruction word, fed to read_in in file order
# E hhhh: expected write_out word, in the order the core emits them
# addi with positive and negative immediates
I 1215
I 7f25
I 8035
I ff45
I 0108
E 0012
I 0208
E 007f
I 0308
E ff80
I f015
I 0108
E 0002
# register ops, then a dependent chain
I 3251
I 0508
E ffff
I 1262
I 0608
E 007d
I 5373
I 0708
E ff80
I 1684
I 0808
E 007f
I 8891
I 1992
I 4994
I 0908
E ff03
# writes to r0 are dropped
I 2101
I 0008
E 0000
I 5505
I 10a1
I 0a08
E 0002
I 0000
# stores at base plus offset, then loads back
I 10b5
I 0b57
I 3b67
I eb97
I 7017
I 3bc6
I 0c08
E 007d
I 0bd6
I 0d08
E ffff
I ebe6
I 0e08
E ff03
I 70f6
I 0f08
E 0002
# load to use, store then load of the same word
I 0bc6
I 1cd1
I 0d08
E 0001
I eee4
I 33e5
I 5be7
I 5bf6
I 0f08
E 0033
# reads two and three slots after the write
I 0115
I 0000
I 0108
E 0003
I 0125
I 0000
I 0000
I 0208
E 0080
# loaded value stored, reloaded and summed
I 3b36
I 1037
I 1046
I 0408
E 007d
I 2451
I 0508
E 00fd
I 0108
E 0003
I 0208
E 0080
